//--- tests/exec_stim.txt
# name dep pc rs1_val rs2_val imm rs1 rs2 rd use_pc use_imm op br hold exp_value exp_taken exp_target
# dep 1 issues right after the previous test; op and br are enum codes; hex words
add 0 00000000 7fffffff 00000001 00000000 1 2 3 0 0 1 0 0 80000000 0 00000000
addi 0 00000000 00000010 00000000 fffffff0 1 2 3 0 1 1 0 0 00000000 0 fffffff0
sub 0 00000000 00000000 00000001 00000000 1 2 3 0 0 2 0 0 ffffffff 0 00000000
and 0 00000000 f0f0f0f0 ff00ff00 00000000 1 2 3 0 0 3 0 0 f000f000 0 00000000
or 0 00000000 f0f0f0f0 0f0f0000 00000000 1 2 3 0 0 4 0 0 fffff0f0 0 00000000
xor 0 00000000 aaaaaaaa ffffffff 00000000 1 2 3 0 0 5 0 0 55555555 0 00000000
slt 0 00000000 ffffffff 00000001 00000000 1 2 3 0 0 6 0 0 00000001 0 00000000
sltu 0 00000000 ffffffff 00000001 00000000 1 2 3 0 0 7 0 0 00000000 0 00000000
sll 0 00000000 00000001 00000021 00000000 1 2 3 0 0 8 0 0 00000002 0 00000000
srl 0 00000000 80000000 0000003f 00000000 1 2 3 0 0 9 0 0 00000001 0 00000000
sra 0 00000000 80000000 00000004 00000000 1 2 3 0 0 10 0 0 f8000000 0 00000000
mul 0 00000000 fffffffe 00000003 00000000 1 2 3 0 0 11 0 0 fffffffa 0 00000000
mulh 0 00000000 80000000 80000000 00000000 1 2 3 0 0 12 0 0 40000000 0 00000000
mulhsu 0 00000000 ffffffff ffffffff 00000000 1 2 3 0 0 13 0 0 ffffffff 0 00000000
mulhu 0 00000000 ffffffff ffffffff 00000000 1 2 3 0 0 14 0 0 fffffffe 0 00000000
mulh_hold 0 00000000 ffffffff 00000005 00000000 1 2 3 0 0 12 0 3 ffffffff 0 00000000
add_hold 0 00000000 00000005 00000006 00000000 1 2 3 0 0 1 0 2 0000000b 0 00000000
auipc 0 00004000 00000000 00000000 00001000 1 2 3 1 1 1 0 0 00005000 0 00005000
fwd_prod 0 00000000 00000010 00000020 00000000 1 2 10 0 0 1 0 0 00000030 0 00000000
fwd_rs1 1 00000000 00000000 00000001 00000000 10 2 11 0 0 1 0 0 00000031 0 00000000
fwd_rs2 1 00000000 00000100 00000000 00000000 1 11 12 0 0 2 0 0 000000cf 0 00000000
fwd_mul 1 00000000 00000000 00000002 00000000 12 2 13 0 0 11 0 0 0000019e 0 00000000
x0_prod 0 00000000 00000005 00000005 00000000 1 2 0 0 0 1 0 0 0000000a 0 00000000
x0_cons 1 00000000 00000000 00000001 00000000 0 2 14 0 0 1 0 0 00000001 0 00000000
beq 0 00001000 00000005 00000005 00000010 1 2 0 0 1 0 1 0 00000000 1 00001010
bne 0 00002000 00000003 00000004 fffffff0 1 2 0 0 1 0 2 0 00000000 1 00001ff0
blt 0 00001000 ffffffff 00000001 00000010 1 2 0 0 1 0 3 0 00000000 1 00001010
bge 0 00001000 ffffffff 00000001 00000010 1 2 0 0 1 0 4 0 00000000 0 00001010
bltu 0 00001000 ffffffff 00000001 00000010 1 2 0 0 1 0 5 0 00000000 0 00001010
bgeu 0 00001000 ffffffff 00000001 00000010 1 2 0 0 1 0 6 0 00000000 1 00001010

//--- filelist.f
logic/exec_pkg.sv
logic/operand_select.sv
logic/mult_unit.sv
logic/alu.sv
logic/exec_result_reg.sv
logic/exec_stage.sv
tests/exec_stage_checker.sv
tests/exec_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f filelist.f --top-module exec_stage_tb -Mdir obj_dir
./obj_dir/Vexec_stage_tb > sim.log 2>&1 || true
cat sim.log
if grep -qx "Test passed" sim.log; then
	exit 0
fi
exit 1

//--- tests/exec_stage_tb.sv
`timescale 1ns/100ps

module exec_stage_tb import exec_pkg::*; ();

	localparam int MAX_TESTS = 64;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_GAP = 3;

	logic CLK = 1'b0;
	logic nrst;
	logic hold;
	issue_t issue;
	logic stall;
	result_t result;

	// Test table from the stim file
	logic [8*12-1:0] names [MAX_TESTS];
	issue_t iss_tab [MAX_TESTS];
	int hold_tab [MAX_TESTS];
	int dep_tab [MAX_TESTS];
	word_t exp_val [MAX_TESTS];
	logic exp_tk [MAX_TESTS];
	word_t exp_tgt [MAX_TESTS];
	logic test_bad [MAX_TESTS];
	// Cycle in which each result must show up
	int due_cycle [MAX_TESTS];

	int ntests = 0;
	int max_hold = 0;
	int chk_idx = 0;
	int passes = 0;
	int fails = 0;
	int errors = 0;
	int setup_errors = 0;
	int cycles = 0;
	int limit = 1000;

	exec_stage #(
		.MUL_EN(1)
	) dut (
		.CLK(CLK),
		.nrst(nrst),
		.hold(hold),
		.issue(issue),
		.stall(stall),
		.result(result)
	);

	bind exec_stage exec_stage_checker u_checker (
		.CLK(CLK),
		.nrst(nrst),
		.hold(hold),
		.stall(stall),
		.result(result)
	);

	always #50 CLK = ~CLK;

	// Run limit, worst case per test plus reset and margin
	always @(posedge CLK) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout after %0d cycles, %0d of %0d results missing",
				cycles, ntests - chk_idx, ntests);
			$display("Test failed");
			$finish;
		end
	end

	task automatic load_stim();
		int fd;
		int code;
		int dep, rs1, rs2, rd, upc, uimm, op, br, hl, tk;
		logic [8*12-1:0] name;
		logic [8*120-1:0] line;
		word_t pc, a, b, imm, ev, et;
		issue_t iss;
		fd = $fopen("tests/exec_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/exec_stim.txt");
			setup_errors++;
		end else begin
			// Skip the two column note lines
			code = $fgets(line, fd);
			code = $fgets(line, fd);
			while (!$feof(fd) && ntests < MAX_TESTS) begin
				code = $fscanf(fd, "%s %d %h %h %h %h %d %d %d %d %d %d %d %d %h %d %h",
					name, dep, pc, a, b, imm, rs1, rs2, rd, upc, uimm, op, br, hl,
					ev, tk, et);
				if (code != 17) begin
					break;
				end
				iss = '0;
				iss.valid = 1'b1;
				iss.pc = pc;
				iss.rs1_val = a;
				iss.rs2_val = b;
				iss.imm = imm;
				iss.rs1 = rs1[4:0];
				iss.rs2 = rs2[4:0];
				iss.rd = rd[4:0];
				iss.use_pc = upc[0];
				iss.use_imm = uimm[0];
				iss.op = alu_op_e'(op[3:0]);
				iss.br = br_type_e'(br[2:0]);
				names[ntests] = name;
				iss_tab[ntests] = iss;
				hold_tab[ntests] = hl;
				dep_tab[ntests] = dep;
				exp_val[ntests] = ev;
				exp_tk[ntests] = tk[0];
				exp_tgt[ntests] = et;
				test_bad[ntests] = 1'b0;
				if (hl > max_hold) begin
					max_hold = hl;
				end
				ntests++;
			end
			$fclose(fd);
		end
	endtask

	// Present one issue, raise hold for its count, wait for acceptance
	task automatic run_test(input int idx);
		int left;
		int stalls;
		int exp_stalls;
		logic done;
		left = hold_tab[idx];
		stalls = 0;
		done = 1'b0;
		issue <= iss_tab[idx];
		hold <= (left > 0);
		while (!done) begin
			@(negedge CLK);
			if (stall && !hold) begin
				stalls++;
			end
			// Loads at the next edge when neither stall nor hold
			done = !stall && !hold;
			if (done) begin
				// Result visible in the cycle after the load edge
				due_cycle[idx] = cycles + 1;
			end
			@(posedge CLK);
			if (left > 0) begin
				left--;
			end
			hold <= (left > 0);
		end
		// RV32M ops stall once, base ops never
		exp_stalls = (iss_tab[idx].op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU}) ? 1 : 0;
		assert (stalls == exp_stalls) else begin
			$display("Error: %0s stall cycles expected %0d actual %0d",
				names[idx], exp_stalls, stalls);
			test_bad[idx] = 1'b1;
		end
	endtask

	// Results compared in issue order
	always @(negedge CLK) begin : check_result
		logic bad;
		if (nrst && result.valid) begin
			if (chk_idx >= ntests) begin
				$display("Unexpected result for rd %0d after the last test", result.rd);
				errors++;
			end else begin
				bad = test_bad[chk_idx];
				assert (cycles == due_cycle[chk_idx]) else begin
					$display("Error: %0s result cycle expected %0d actual %0d",
						names[chk_idx], due_cycle[chk_idx], cycles);
					bad = 1'b1;
				end
				assert (result.value == exp_val[chk_idx]) else begin
					$display("Error: %0s value expected %h actual %h",
						names[chk_idx], exp_val[chk_idx], result.value);
					bad = 1'b1;
				end
				assert (result.taken == exp_tk[chk_idx]) else begin
					$display("Error: %0s taken expected %0d actual %0d",
						names[chk_idx], exp_tk[chk_idx], result.taken);
					bad = 1'b1;
				end
				assert (result.target == exp_tgt[chk_idx]) else begin
					$display("Error: %0s target expected %h actual %h",
						names[chk_idx], exp_tgt[chk_idx], result.target);
					bad = 1'b1;
				end
				assert (result.rd == iss_tab[chk_idx].rd) else begin
					$display("Error: %0s rd expected %0d actual %0d",
						names[chk_idx], iss_tab[chk_idx].rd, result.rd);
					bad = 1'b1;
				end
				$display("%0s finished, %0s", names[chk_idx], bad ? "mismatch" : "ok");
				if (bad) begin
					fails++;
				end else begin
					passes++;
				end
				chk_idx++;
			end
		end
	end

	initial begin
		int gap;
		nrst = 1'b0;
		hold = 1'b0;
		issue = '0;
		void'($urandom(5));
		load_stim();
		limit = ntests * (2 + max_hold + MAX_GAP) + RESET_CYCLES + 40;
		repeat (RESET_CYCLES) @(posedge CLK);
		nrst <= 1'b1;
		// Idle stage after reset
		repeat (2) begin
			@(negedge CLK);
			assert (!result.valid && !stall) else begin
				$display("Error: idle valid and stall expected 0 0 actual %b %b",
					result.valid, stall);
				setup_errors++;
			end
		end
		@(posedge CLK);
		for (int i = 0; i < ntests; i++) begin
			// Dependent tests follow at once so the bypass is live
			if (dep_tab[i] == 0) begin
				gap = $urandom_range(MAX_GAP, 0);
				if (gap > 0) begin
					issue <= '0;
					repeat (gap) @(posedge CLK);
				end
			end
			run_test(i);
		end
		issue <= '0;
		wait (chk_idx >= ntests);
		repeat (3) @(posedge CLK);
		$display("Results: %0d tests, %0d ok, %0d mismatched, %0d other errors",
			ntests, passes, fails, errors + setup_errors);
		if (ntests > 0 && passes == ntests && fails == 0 && errors + setup_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- tests/exec_stage_checker.sv
`timescale 1ns/100ps

module exec_stage_checker import exec_pkg::*; (
	input logic CLK,
	input logic nrst,
	input logic hold,
	input logic stall,
	input result_t result
);

	// Multiply stall lasts one cycle once hold is gone
	stall_one_cycle: assert property (@(posedge CLK) disable iff (!nrst)
		stall && !hold |=> !stall)
		else $error("stall stayed high for two cycles without hold");

	// Reset clears the result register
	reset_no_valid: assert property (@(posedge CLK)
		!nrst |=> !result.valid)
		else $error("result valid high during reset");

	// Hold blocks the load of the result register
	hold_no_valid: assert property (@(posedge CLK) disable iff (!nrst)
		hold |=> !result.valid)
		else $error("result valid right after a hold cycle");

endmodule

//--- logic/exec_stage.sv
`timescale 1ns/100ps

module exec_stage import exec_pkg::*; #(
	parameter int MUL_EN = 1
) (
	input logic CLK,
	input logic nrst,
	input logic hold,
	input issue_t issue,
	output logic stall,
	output result_t result
);

	word_t op_a;
	word_t op_b;
	word_t target;
	word_t res;
	alu_op_e op;
	br_type_e br;
	logic valid;
	reg_addr_t rd;
	logic eq;
	logic lt;
	logic ltu;

	// Operands with bypass from the result register
	operand_select u_sel (
		.issue(issue),
		.fwd(result),
		.op_a(op_a),
		.op_b(op_b),
		.target(target),
		.op(op),
		.br(br),
		.valid(valid),
		.rd(rd)
	);

	// Arithmetic, multiply and flags
	alu #(
		.MUL_EN(MUL_EN)
	) u_alu (
		.CLK(CLK),
		.nrst(nrst),
		.hold(hold),
		.op_a(op_a),
		.op_b(op_b),
		.op(op),
		.res(res),
		.stall(stall),
		.eq(eq),
		.lt(lt),
		.ltu(ltu)
	);

	// Branch decision and stage register
	exec_result_reg u_res (
		.CLK(CLK),
		.nrst(nrst),
		.hold(hold),
		.stall(stall),
		.valid(valid),
		.rd(rd),
		.res(res),
		.target(target),
		.br(br),
		.eq(eq),
		.lt(lt),
		.ltu(ltu),
		.result(result)
	);

endmodule

//--- logic/exec_result_reg.sv
`timescale 1ns/100ps

module exec_result_reg import exec_pkg::*; (
	input logic CLK,
	input logic nrst,
	input logic hold,
	input logic stall,
	input logic valid,
	input reg_addr_t rd,
	input word_t res,
	input word_t target,
	input br_type_e br,
	input logic eq,
	input logic lt,
	input logic ltu,
	output result_t result
);

	logic cond;
	logic load;
	logic valid_q;
	logic taken_q;
	reg_addr_t rd_q;
	word_t value_q;
	word_t target_q;

	// Branch condition from the ALU flags
	always_comb begin
		case (br)
			BR_BEQ: cond = eq;
			BR_BNE: cond = ~eq;
			BR_BLT: cond = lt;
			BR_BGE: cond = ~lt;
			BR_BLTU: cond = ltu;
			BR_BGEU: cond = ~ltu;
			default: cond = 1'b0;
		endcase
	end

	// Instruction completes this cycle
	assign load = valid & ~stall & ~hold;

	// Control fields
	// valid is a one-cycle pulse per instruction
	always_ff @(posedge CLK) begin
		if (!nrst) begin
			valid_q <= 1'b0;
			rd_q <= '0;
			taken_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
			rd_q <= rd;
			taken_q <= cond;
		end else begin
			valid_q <= 1'b0;
		end
	end

	// Payload kept between loads for the bypass path
	always_ff @(posedge CLK) begin
		if (load) begin
			value_q <= res;
			target_q <= target;
		end
	end

	assign result = '{valid: valid_q, rd: rd_q, value: value_q, taken: taken_q, target: target_q};

endmodule

//--- logic/alu.sv
`timescale 1ns/100ps

module alu import exec_pkg::*; #(
	// Multiplier present when nonzero
	parameter int MUL_EN = 1
) (
	input logic CLK,
	input logic nrst,
	input logic hold,
	input word_t op_a,
	input word_t op_b,
	input alu_op_e op,
	output word_t res,
	output logic stall,
	output logic eq,
	output logic lt,
	output logic ltu
);

	logic is_mul;
	shamt_t shamt;
	logic [2*XLEN-1:0] prod;

	// Comparison flags, shared by slt and branches
	assign eq = (op_a == op_b);
	assign lt = ($signed(op_a) < $signed(op_b));
	assign ltu = (op_a < op_b);

	// Only five bits of the shift amount count
	assign shamt = op_b[4:0];

	assign is_mul = (op inside {ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU});

	generate
		if (MUL_EN != 0) begin : g_mul
			logic stall_q;
			logic sign_a;
			logic sign_b;
			logic signed [XLEN:0] mul_a;
			logic signed [XLEN:0] mul_b;
			logic signed [2*XLEN+1:0] mul_p;

			// Signed operands for mulh, mixed for mulhsu
			assign sign_a = (op == ALU_MULH) || (op == ALU_MULHSU);
			assign sign_b = (op == ALU_MULH);

			// Extend to 33 bits so one signed multiplier covers all kinds
			assign mul_a = {sign_a & op_a[XLEN-1], op_a};
			assign mul_b = {sign_b & op_b[XLEN-1], op_b};

			// First cycle of a multiply stalls
			// cleared once the stall register advances
			always_ff @(posedge CLK) begin
				if (!nrst) begin
					stall_q <= 1'b0;
				end else if (!hold) begin
					stall_q <= is_mul & stall;
				end
			end

			assign stall = is_mul & ~stall_q;

			// Product captured during the stall cycle
			mult_unit #(
				.W(XLEN + 1)
			) u_mult (
				.CLK(CLK),
				.ce(stall),
				.a(mul_a),
				.b(mul_b),
				.p(mul_p)
			);

			// Upper two bits are extension only
			assign prod = mul_p[2*XLEN-1:0];
		end else begin : g_no_mul
			// No multiplier, multiplies read zero and never stall
			assign stall = 1'b0;
			assign prod = '0;
		end
	endgenerate

	// Result select
	always_comb begin
		case (op)
			ALU_ADD: res = op_a + op_b;
			ALU_SUB: res = op_a - op_b;
			ALU_AND: res = op_a & op_b;
			ALU_OR: res = op_a | op_b;
			ALU_XOR: res = op_a ^ op_b;
			ALU_SLT: res = {{(XLEN-1){1'b0}}, lt};
			ALU_SLTU: res = {{(XLEN-1){1'b0}}, ltu};
			ALU_SLL: res = op_a << shamt;
			ALU_SRL: res = op_a >> shamt;
			// Arithmetic shift keeps the sign
			ALU_SRA: res = $signed(op_a) >>> shamt;
			// Low product word, same for any signedness
			ALU_MUL: res = prod[XLEN-1:0];
			ALU_MULH, ALU_MULHSU, ALU_MULHU: res = prod[2*XLEN-1:XLEN];
			default: res = '0;
		endcase
	end

endmodule

//--- logic/mult_unit.sv
`timescale 1ns/100ps

module mult_unit #(
	// Operand width, one extra bit for unsigned operands
	parameter int W = 33
) (
	input logic CLK,
	input logic ce,
	input logic signed [W-1:0] a,
	input logic signed [W-1:0] b,
	output logic signed [2*W-1:0] p
);

	// Full signed product of both operands
	logic signed [2*W-1:0] prod;

	// Sign handling is done by the caller
	// through the extension bit
	assign prod = a * b;

	// Product register
	// Holds its value while ce is low, so the
	// second multiply cycle sees a stable word
	always_ff @(posedge CLK) begin
		if (ce) begin
			p <= prod;
		end
	end

endmodule

//--- logic/operand_select.sv
`timescale 1ns/100ps

module operand_select import exec_pkg::*; (
	input issue_t issue,
	input result_t fwd,
	output word_t op_a,
	output word_t op_b,
	output word_t target,
	output alu_op_e op,
	output br_type_e br,
	output logic valid,
	output reg_addr_t rd
);

	logic fwd_ok;
	logic fwd_rs1;
	logic fwd_rs2;
	logic is_br;
	word_t rs1_val;
	word_t rs2_val;

	// Registered result usable for bypass
	// x0 always reads as the register file value
	assign fwd_ok = fwd.valid && (fwd.rd != '0);
	assign fwd_rs1 = fwd_ok && (fwd.rd == issue.rs1);
	assign fwd_rs2 = fwd_ok && (fwd.rd == issue.rs2);

	// Source values after bypass
	assign rs1_val = fwd_rs1 ? fwd.value : issue.rs1_val;
	assign rs2_val = fwd_rs2 ? fwd.value : issue.rs2_val;

	// Branches compare rs1 against rs2
	assign is_br = (issue.br != BR_NONE);

	// Operand a, PC for auipc and jumps
	assign op_a = (issue.use_pc && !is_br) ? issue.pc : rs1_val;

	// Operand b, immediate only outside branches
	assign op_b = (issue.use_imm && !is_br) ? issue.imm : rs2_val;

	// Branch and jump target
	assign target = issue.pc + issue.imm;

	// Idle slots carry no operation
	// keeps the multiply stall low between issues
	assign op = issue.valid ? issue.op : ALU_NONE;
	assign br = issue.valid ? issue.br : BR_NONE;

	assign valid = issue.valid;
	assign rd = issue.rd;

endmodule

//--- logic/exec_pkg.sv
package exec_pkg;

	// Data path width
	localparam int XLEN = 32;

	// Widths with a meaning in the execute stage
	typedef logic [XLEN-1:0] word_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] shamt_t;

	// ALU operation codes
	// Code 15 is unused and gives zero
	typedef enum logic [3:0] {
		ALU_NONE   = 4'd0,
		ALU_ADD    = 4'd1,
		ALU_SUB    = 4'd2,
		ALU_AND    = 4'd3,
		ALU_OR     = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SLT    = 4'd6,
		ALU_SLTU   = 4'd7,
		ALU_SLL    = 4'd8,
		ALU_SRL    = 4'd9,
		ALU_SRA    = 4'd10,
		ALU_MUL    = 4'd11,
		ALU_MULH   = 4'd12,
		ALU_MULHSU = 4'd13,
		ALU_MULHU  = 4'd14
	} alu_op_e;

	// Branch kinds, BR_NONE for plain ALU work
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_BEQ  = 3'd1,
		BR_BNE  = 3'd2,
		BR_BLT  = 3'd3,
		BR_BGE  = 3'd4,
		BR_BLTU = 3'd5,
		BR_BGEU = 3'd6
	} br_type_e;

	// Issue bundle from decode
	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     rs1_val;
		word_t     rs2_val;
		word_t     imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		logic      use_pc;
		logic      use_imm;
		alu_op_e   op;
		br_type_e  br;
	} issue_t;

	// Result bundle toward the memory stage
	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     value;
		logic      taken;
		word_t     target;
	} result_t;

endpackage
